//--- fetch_macros.svh
// Instruction cache geometry and PC field widths for the fetch unit.
// Included by the type package and by each block that sizes an array
// or slices an address.
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Two ways, so the way index is a single bit
`define FETCH_WAYS 2
`define FETCH_SETS 16

// Words per 16-byte line
`define LINE_WORDS 4

// A PC splits into {tag, set, offset}
`define OFFSET_BITS 4
`define SET_BITS 4
`define TAG_BITS 24

`endif

//--- fetch_types_pkg.sv
// Vector types for addresses, cache indexes and line data.
// Imported by wildcard in the header of each module that uses them.
`default_nettype none

`include "fetch_macros.svh"

package fetch_types_pkg;

    // Instruction or address word
    typedef logic [31:0] word_t;

    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_idx_t;
    typedef logic [$clog2(`FETCH_WAYS)-1:0] way_idx_t;

    // Line address is {tag, set}
    typedef logic [`TAG_BITS+`SET_BITS-1:0] line_addr_t;

    // Word 0 in bits 127:96, as it arrives from memory
    typedef logic [`LINE_WORDS*32-1:0] line_data_t;

endpackage

`default_nettype wire

//--- fetch_ctl_pkg.sv
// State encodings for the tag stage and the line fill FSMs.
`default_nettype none

package fetch_ctl_pkg;

    typedef enum logic [1:0]
    {
        TS_IDLE,
        TS_WAIT_FILL,
        TS_RETRY
    } tag_state_t;

    typedef enum logic [1:0]
    {
        FS_IDLE,
        FS_READ,
        FS_WRITE_TAG,
        FS_WRITE_DATA
    } fill_state_t;

endpackage

`default_nettype wire

//--- fetch_if.sv
// Internal buses of the fetch unit.
// tag_data_if links the tag stage to the data stage, fill_if links the
// fill engine to both pipeline stages.
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

interface tag_data_if import fetch_types_pkg::*; ();
    logic req;
    word_t pc;
    tag_t tags [`FETCH_WAYS];
    logic valids [`FETCH_WAYS];
    way_idx_t lru_way;

    // Back from the data stage
    logic lru_update_en;
    way_idx_t lru_update_way;
    logic near_miss;

    modport tag
    (
        output req, pc, tags, valids, lru_way,
        input lru_update_en, lru_update_way, near_miss
    );

    modport data
    (
        input req, pc, tags, valids, lru_way,
        output lru_update_en, lru_update_way, near_miss
    );
endinterface

interface fill_if import fetch_types_pkg::*; ();
    logic miss_en;
    line_addr_t miss_line;
    way_idx_t miss_way;
    logic busy;
    logic tag_update_en;
    set_idx_t update_set;
    way_idx_t update_way;
    tag_t update_tag;
    logic data_update_en;
    line_data_t update_data;

    modport stage
    (
        input miss_en, busy, tag_update_en, update_set, update_way, update_tag,
        input data_update_en
    );

    modport data
    (
        output miss_en, miss_line, miss_way,
        input tag_update_en, update_set, update_way, update_tag,
        input data_update_en, update_data
    );

    modport fill
    (
        input miss_en, miss_line, miss_way,
        output busy, tag_update_en, update_set, update_way, update_tag,
        output data_update_en, update_data
    );
endinterface

`default_nettype wire

//--- ifetch_tag_stage.sv
// First fetch stage. Takes a request, holds its PC and reads the tags,
// valid bits and LRU state for the data stage one cycle later.
// Re-issues the held PC after a near miss or when a line fill lands.
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module ifetch_tag_stage
    import fetch_types_pkg::*;
    import fetch_ctl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic flush,
    input logic fetch_valid,
    input word_t fetch_pc,
    output logic fetch_ready,
    tag_data_if.tag td,
    fill_if.stage fl
);
    tag_state_t state;
    tag_state_t state_next;
    word_t pc_q;
    logic pend_q;
    logic req_q;
    word_t req_pc_q;
    tag_t tag_mem [`FETCH_WAYS][`FETCH_SETS];
    logic [`FETCH_SETS-1:0] valid_mem [`FETCH_WAYS];
    logic [`FETCH_SETS-1:0] lru_q;
    tag_t tags_q [`FETCH_WAYS];
    logic valids_q [`FETCH_WAYS];
    logic [`FETCH_WAYS-1:0] fill_fwd;
    set_idx_t rd_set;
    set_idx_t req_set;
    logic accept;
    logic reissue;

    assign rd_set = pc_q[`OFFSET_BITS +: `SET_BITS];
    assign req_set = req_pc_q[`OFFSET_BITS +: `SET_BITS];

    // Only one request in flight, so results stay in order across a miss
    assign fetch_ready = state == TS_IDLE && !pend_q && !td.near_miss && !fl.busy;
    assign accept = fetch_valid && fetch_ready;
    assign reissue = td.near_miss
        || (state == TS_WAIT_FILL && fl.data_update_en && !flush);

    // A tag written this cycle must be seen by the read at this edge
    always_comb
    begin
        for (int w = 0; w < `FETCH_WAYS; w++)
            fill_fwd[w] = fl.tag_update_en && fl.update_way == way_idx_t'(w)
                && fl.update_set == rd_set;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            TS_IDLE:
            begin
                if (fl.miss_en)
                    state_next = TS_WAIT_FILL;
                else if (td.near_miss)
                    state_next = TS_RETRY;
            end
            TS_WAIT_FILL:
            begin
                if (fl.data_update_en)
                    state_next = TS_RETRY;
            end
            default:
            begin
                // Re-issued request is in the data stage
                if (fl.miss_en)
                    state_next = TS_WAIT_FILL;
                else if (!td.near_miss)
                    state_next = TS_IDLE;
            end
        endcase
        if (flush)
            state_next = TS_IDLE;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= TS_IDLE;
            pend_q <= 1'b0;
            req_q <= 1'b0;
            lru_q <= '0;
            for (int w = 0; w < `FETCH_WAYS; w++)
            begin
                valid_mem[w] <= '0;
                valids_q[w] <= 1'b0;
            end
        end
        else
        begin
            state <= state_next;
            pend_q <= accept;
            req_q <= pend_q || reissue;
            // LRU bit holds the victim, the way not just used
            if (td.lru_update_en)
                lru_q[req_set] <= ~td.lru_update_way;
            for (int w = 0; w < `FETCH_WAYS; w++)
            begin
                if (fl.tag_update_en && fl.update_way == way_idx_t'(w))
                    valid_mem[w][fl.update_set] <= 1'b1;
                valids_q[w] <= valid_mem[w][rd_set] || fill_fwd[w];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            pc_q <= fetch_pc;
        req_pc_q <= pc_q;
        if (fl.tag_update_en)
            tag_mem[fl.update_way][fl.update_set] <= fl.update_tag;
        for (int w = 0; w < `FETCH_WAYS; w++)
            tags_q[w] <= fill_fwd[w] ? fl.update_tag : tag_mem[w][rd_set];
    end

    assign td.req = req_q;
    assign td.pc = req_pc_q;
    assign td.tags = tags_q;
    assign td.valids = valids_q;
    assign td.lru_way = way_idx_t'(lru_q[req_set]);

endmodule

`default_nettype wire

//--- ifetch_data_stage.sv
// Second fetch stage. Checks the tags read by the tag stage, reads the
// hit line and returns the byte-swapped instruction word one cycle later.
// Reports alignment faults, starts line fills on a miss and asks the
// tag stage to retry when the line is being installed this cycle.
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module ifetch_data_stage
    import fetch_types_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic flush,
    tag_data_if.data td,
    fill_if.data fl,
    output logic inst_valid,
    output word_t inst_word,
    output word_t inst_pc,
    output logic align_fault
);
    line_data_t data_mem [`FETCH_WAYS][`FETCH_SETS];
    tag_t pc_tag;
    set_idx_t pc_set;
    logic [`OFFSET_BITS-3:0] lane;
    logic [`FETCH_WAYS-1:0] way_hit;
    logic cache_hit;
    way_idx_t hit_way;
    logic active;
    logic misaligned;
    line_data_t line;
    word_t fetched;
    word_t swapped;

    assign pc_tag = td.pc[`OFFSET_BITS+`SET_BITS +: `TAG_BITS];
    assign pc_set = td.pc[`OFFSET_BITS +: `SET_BITS];
    assign misaligned = td.pc[1:0] != 2'b00;
    assign active = td.req && !flush;

    always_comb
    begin
        for (int w = 0; w < `FETCH_WAYS; w++)
            way_hit[w] = td.valids[w] && td.tags[w] == pc_tag;
    end

    assign cache_hit = |way_hit;
    // With two ways the upper hit bit is the way index
    assign hit_way = way_idx_t'(way_hit[1]);

    // Tag written this cycle for the line we want, data follows next cycle
    assign td.near_miss = active && !misaligned && !cache_hit
        && fl.tag_update_en
        && fl.update_set == pc_set
        && fl.update_tag == pc_tag;

    assign fl.miss_en = active && !misaligned && !cache_hit && !td.near_miss;
    assign fl.miss_line = {pc_tag, pc_set};
    assign fl.miss_way = td.lru_way;

    assign td.lru_update_en = active && !misaligned && cache_hit;
    assign td.lru_update_way = hit_way;

    // Data written this cycle is not yet in the array
    always_comb
    begin
        if (fl.data_update_en && fl.update_way == hit_way && fl.update_set == pc_set)
            line = fl.update_data;
        else
            line = data_mem[hit_way][pc_set];
    end

    // Word 0 sits in the top lane, so invert the offset
    assign lane = ~td.pc[`OFFSET_BITS-1:2];
    assign fetched = line[32 * lane +: 32];

    // Memory is big-endian
    assign swapped = {fetched[7:0], fetched[15:8], fetched[23:16], fetched[31:24]};

    always_ff @(posedge clk)
    begin
        if (fl.data_update_en)
            data_mem[fl.update_way][fl.update_set] <= fl.update_data;
        inst_word <= swapped;
        inst_pc <= td.pc;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            inst_valid <= 1'b0;
            align_fault <= 1'b0;
        end
        else
        begin
            inst_valid <= active && !misaligned && cache_hit;
            align_fault <= active && misaligned;
        end
    end

endmodule

`default_nettype wire

//--- line_fill_unit.sv
// Line fill engine. On a miss it reads the four words of the line as a
// Wishbone classic master, one single-read cycle per word, then writes
// the tag and, one cycle later, the line data into the cache.
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module line_fill_unit
    import fetch_types_pkg::*;
    import fetch_ctl_pkg::*;
(
    input logic clk,
    input logic reset,
    fill_if.fill fl,
    output logic wb_cyc,
    output logic wb_stb,
    output word_t wb_adr,
    input word_t wb_rdata,
    input logic wb_ack
);
    localparam int BEAT_BITS = `OFFSET_BITS - 2;

    fill_state_t state;
    line_addr_t line_q;
    way_idx_t way_q;
    logic [BEAT_BITS-1:0] beat;
    logic [BEAT_BITS-1:0] lane;
    line_data_t line_buf;
    logic last_beat;
    logic beat_done;

    assign last_beat = beat == BEAT_BITS'(`LINE_WORDS - 1);
    assign beat_done = state == FS_READ && wb_stb && wb_ack;

    // Word address steps up from the line base
    assign wb_adr = {line_q, beat, 2'b00};

    // First word goes to the top lane
    assign lane = ~beat;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= FS_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            beat <= '0;
        end
        else
        begin
            case (state)
                FS_IDLE:
                begin
                    if (fl.miss_en)
                    begin
                        state <= FS_READ;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        beat <= '0;
                    end
                end
                FS_READ:
                begin
                    if (beat_done)
                    begin
                        // Drop the strobe for a cycle between beats
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        if (last_beat)
                            state <= FS_WRITE_TAG;
                        else
                            beat <= beat + 1'b1;
                    end
                    else if (!wb_stb)
                    begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                FS_WRITE_TAG:
                    state <= FS_WRITE_DATA;
                FS_WRITE_DATA:
                    state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == FS_IDLE && fl.miss_en)
        begin
            line_q <= fl.miss_line;
            way_q <= fl.miss_way;
        end
        if (beat_done)
            line_buf[32 * lane +: 32] <= wb_rdata;
    end

    assign fl.busy = fl.miss_en || state != FS_IDLE;
    assign fl.tag_update_en = state == FS_WRITE_TAG;
    assign fl.data_update_en = state == FS_WRITE_DATA;
    assign fl.update_set = line_q[`SET_BITS-1:0];
    assign fl.update_tag = line_q[`SET_BITS +: `TAG_BITS];
    assign fl.update_way = way_q;
    assign fl.update_data = line_buf;

endmodule

`default_nettype wire

//--- ifetch_top.sv
// Top of the instruction fetch unit.
// Fetch requests in, instructions and alignment faults out, and a
// read-only Wishbone classic master port for line fills.
`timescale 1ns/1ps
`default_nettype none

module ifetch_top
    import fetch_types_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic flush,

    // Fetch request
    input logic fetch_valid,
    input word_t fetch_pc,
    output logic fetch_ready,

    // Results
    output logic inst_valid,
    output word_t inst_word,
    output word_t inst_pc,
    output logic align_fault,

    // Wishbone master
    output logic wb_cyc,
    output logic wb_stb,
    output word_t wb_adr,
    input word_t wb_rdata,
    input logic wb_ack
);
    tag_data_if td_bus ();
    fill_if fill_bus ();

    ifetch_tag_stage u_tag_stage
    (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc),
        .fetch_ready(fetch_ready),
        .td(td_bus.tag),
        .fl(fill_bus.stage)
    );

    ifetch_data_stage u_data_stage
    (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .td(td_bus.data),
        .fl(fill_bus.data),
        .inst_valid(inst_valid),
        .inst_word(inst_word),
        .inst_pc(inst_pc),
        .align_fault(align_fault)
    );

    line_fill_unit u_line_fill
    (
        .clk(clk),
        .reset(reset),
        .fl(fill_bus.fill),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_rdata(wb_rdata),
        .wb_ack(wb_ack)
    );

endmodule

`default_nettype wire

//--- ifetch_properties.sv
// Concurrent assertions on the fetch unit top level.
// Bound into ifetch_top by the testbench; fail_count is read at the end of the run.
`timescale 1ns/1ps
`default_nettype none

module ifetch_properties
    import fetch_types_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input word_t wb_adr,
    input logic inst_valid,
    input logic align_fault
);
    int fail_count = 0;

    // Strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else
    begin
        fail_count++;
        $error("wb_stb high without wb_cyc");
    end

    // Address and strobe held while the slave stalls
    a_adr_hold: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else
    begin
        fail_count++;
        $error("wb_adr or wb_stb changed before wb_ack");
    end

    a_flag_excl: assert property (@(posedge clk) disable iff (reset)
        !(inst_valid && align_fault))
    else
    begin
        fail_count++;
        $error("inst_valid and align_fault high together");
    end

endmodule

`default_nettype wire

//--- ifetch_checker.sv
// Watches the fetch unit ports and compares them with a model cache.
// Keeps the accepted requests in order, prints one line per request and
// exposes error and completion counts to the testbench top.
`timescale 1ns/1ps
`default_nettype none

module ifetch_checker
    import fetch_types_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic flush,
    input logic fetch_valid,
    input logic fetch_ready,
    input word_t fetch_pc,
    input logic inst_valid,
    input word_t inst_word,
    input word_t inst_pc,
    input logic align_fault,
    input logic wb_cyc,
    input logic wb_stb,
    input word_t wb_adr,
    input logic wb_ack
);
    localparam word_t MEM_KEY = 32'hc3a5_5a3c;
    localparam int KIND_HIT = 0;
    localparam int KIND_MISS = 1;
    localparam int KIND_FAULT = 2;

    tag_t model_tag [2][16];
    logic model_valid [2][16];
    logic model_lru [16];
    word_t q_pc [$];
    int q_acc [$];
    int q_kind [$];
    logic q_flushed [$];
    int cyc = 0;
    int beats = 0;
    logic test_bad = 1'b0;
    int error_count = 0;
    int done_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    // Memory is big-endian, the core wants little-endian words
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic int classify(input word_t pc);
        if (pc[1:0] != 2'b00)
            return KIND_FAULT;
        for (int w = 0; w < 2; w++)
            if (model_valid[w][pc[7:4]] && model_tag[w][pc[7:4]] == pc[31:8])
                return KIND_HIT;
        return KIND_MISS;
    endfunction

    task automatic note_fail(input string msg);
        $display("%0t: %s (pc %h)", $time, msg, q_pc.size() != 0 ? q_pc[0] : 32'h0);
        error_count++;
        test_bad = 1'b1;
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t got);
        if (expected !== got)
        begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, got);
            error_count++;
            test_bad = 1'b1;
        end
    endtask

    // Hit refreshes LRU, a fill takes the victim way
    task automatic update_model(input word_t pc, input int kind);
        int victim;
        if (kind == KIND_HIT)
        begin
            for (int w = 0; w < 2; w++)
                if (model_valid[w][pc[7:4]] && model_tag[w][pc[7:4]] == pc[31:8])
                    model_lru[pc[7:4]] = ~w[0];
        end
        else if (kind == KIND_MISS)
        begin
            victim = int'(model_lru[pc[7:4]]);
            model_tag[victim][pc[7:4]] = pc[31:8];
            model_valid[victim][pc[7:4]] = 1'b1;
            model_lru[pc[7:4]] = ~victim[0];
        end
    endtask

    task automatic retire();
        string kind_name;
        kind_name = q_flushed[0] ? "flushed" : q_kind[0] == KIND_HIT ? "hit"
            : q_kind[0] == KIND_MISS ? "miss" : "fault";
        $display("test %0d pc %h %s: %s", done_count, q_pc[0], kind_name,
            test_bad ? "FAIL" : "ok");
        if (test_bad)
            fail_count++;
        else
            pass_count++;
        done_count++;
        void'(q_pc.pop_front());
        void'(q_acc.pop_front());
        void'(q_kind.pop_front());
        void'(q_flushed.pop_front());
        beats = 0;
        test_bad = 1'b0;
    endtask

    initial
    begin
        for (int s = 0; s < 16; s++)
        begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s] = 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (flush && q_pc.size() != 0 && cyc == q_acc[0] + 2)
                q_flushed[0] = 1'b1;

            if (wb_cyc && (q_pc.size() == 0 || q_flushed[0] || q_kind[0] != KIND_MISS))
                note_fail("Wishbone cycle while no fill is expected");
            else if (wb_cyc && wb_stb && wb_ack)
            begin
                compare_word("wb_adr", {q_pc[0][31:4], beats[1:0], 2'b00}, wb_adr);
                beats++;
                if (beats > 4)
                    note_fail("more than four Wishbone reads for one line");
            end

            if (inst_valid || align_fault)
            begin
                if (q_pc.size() == 0)
                    note_fail("result with no request pending");
                else if (q_flushed[0])
                begin
                    note_fail("flushed request produced a result");
                    retire();
                end
                else if (align_fault)
                begin
                    if (q_kind[0] != KIND_FAULT)
                        note_fail("align_fault on an aligned PC");
                    else if (cyc != q_acc[0] + 3)
                        note_fail("align_fault not two cycles after acceptance");
                    retire();
                end
                else
                begin
                    if (q_kind[0] == KIND_FAULT)
                        note_fail("misaligned PC gave inst_valid");
                    compare_word("inst_pc", q_pc[0], inst_pc);
                    compare_word("inst_word", swap_bytes({q_pc[0][31:2], 2'b00} ^ MEM_KEY),
                        inst_word);
                    if (q_kind[0] == KIND_HIT && cyc != q_acc[0] + 3)
                        note_fail("hit result not two cycles after acceptance");
                    if (q_kind[0] == KIND_MISS && beats != 4)
                        note_fail("miss finished without four Wishbone reads");
                    update_model(q_pc[0], q_kind[0]);
                    retire();
                end
            end
            else if (q_pc.size() != 0 && cyc >= q_acc[0] + 3
                && (q_flushed[0] || q_kind[0] != KIND_MISS))
            begin
                if (!q_flushed[0])
                    note_fail("no result two cycles after acceptance");
                retire();
            end

            if (fetch_valid && fetch_ready)
            begin
                q_pc.push_back(fetch_pc);
                q_acc.push_back(cyc);
                q_kind.push_back(classify(fetch_pc));
                q_flushed.push_back(1'b0);
            end
        end
        cyc++;
    end

endmodule

`default_nettype wire

//--- tb_ifetch.sv
// Testbench top for the instruction fetch unit.
// Issues directed then seeded random fetches one at a time, models the
// Wishbone memory with random wait states and prints the final verdict.
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch
    import fetch_types_pkg::*;
();

    localparam int NUM_DIRECTED = 7;
    localparam int NUM_RANDOM = 160;
    localparam int NUM_REQ = NUM_DIRECTED + NUM_RANDOM;
    // Four beats of up to 3 waits plus the gap, tag and data writes and retry
    localparam int CYCLES_PER_REQ = 40;
    localparam word_t MEM_KEY = 32'hc3a5_5a3c;

    logic clk;
    logic reset;
    logic flush;
    logic fetch_valid;
    word_t fetch_pc;
    logic fetch_ready;
    logic inst_valid;
    word_t inst_word;
    word_t inst_pc;
    logic align_fault;
    logic wb_cyc;
    logic wb_stb;
    word_t wb_adr;
    word_t wb_rdata = '0;
    logic wb_ack = 1'b0;
    int unsigned wait_cnt = 0;

    // Three tags in set 3 force an eviction and the evicted line returns later
    word_t directed_pc [NUM_DIRECTED] = '{32'h0000_1030, 32'h0000_1134, 32'h0000_1238,
        32'h0000_1030, 32'h0000_1131, 32'h0000_123c, 32'h0000_1134};
    logic directed_flush [NUM_DIRECTED] = '{0, 0, 0, 0, 0, 1, 0};

    ifetch_top u_dut
    (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc),
        .fetch_ready(fetch_ready),
        .inst_valid(inst_valid),
        .inst_word(inst_word),
        .inst_pc(inst_pc),
        .align_fault(align_fault),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_rdata(wb_rdata),
        .wb_ack(wb_ack)
    );

    ifetch_checker u_checker
    (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready),
        .fetch_pc(fetch_pc),
        .inst_valid(inst_valid),
        .inst_word(inst_word),
        .inst_pc(inst_pc),
        .align_fault(align_fault),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_ack(wb_ack)
    );

    bind ifetch_top ifetch_properties u_props
    (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_ack(wb_ack),
        .wb_adr(wb_adr),
        .inst_valid(inst_valid),
        .align_fault(align_fault)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // Memory slave that acks each strobe after 0 to 3 wait states
    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wb_ack <= 1'b0;
            wait_cnt <= 0;
        end
        else
        begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack)
            begin
                if (wait_cnt == 0)
                begin
                    wb_ack <= 1'b1;
                    wb_rdata <= wb_adr ^ MEM_KEY;
                    wait_cnt <= $urandom % 4;
                end
                else
                    wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // Few tags over two sets with an occasional misaligned PC
    function automatic word_t random_pc();
        tag_t tag;
        set_idx_t set;
        logic [1:0] word;
        logic [1:0] low;
        tag = 24'h10 + tag_t'($urandom % 4);
        set = ($urandom % 2) != 0 ? 4'h3 : 4'h7;
        word = 2'($urandom % 4);
        low = ($urandom % 10) == 0 ? 2'(1 + $urandom % 3) : 2'b00;
        return {tag, set, word, low};
    endfunction

    task automatic fetch_one(input word_t pc, input logic with_flush);
        int start;
        start = u_checker.done_count;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc <= pc;
        do
            @(negedge clk);
        while (!fetch_ready);
        @(posedge clk);
        fetch_valid <= 1'b0;
        // Flush lands in the data-stage cycle of this request
        if (with_flush)
        begin
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        do
            @(negedge clk);
        while (u_checker.done_count == start);
    endtask

    initial
    begin
        reset = 1'b1;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        void'($urandom(32'h1a0b));
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_DIRECTED; i++)
            fetch_one(directed_pc[i], directed_flush[i]);
        for (int i = 0; i < NUM_RANDOM; i++)
            fetch_one(random_pc(), ($urandom % 8) == 0);
        repeat (4) @(posedge clk);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
            u_checker.done_count, u_checker.pass_count, u_checker.fail_count,
            u_checker.error_count, u_dut.u_props.fail_count);
        if (u_checker.error_count == 0 && u_dut.u_props.fail_count == 0
            && u_checker.done_count == NUM_REQ)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        repeat (NUM_REQ * CYCLES_PER_REQ + 10) @(posedge clk);
        $display("Timeout: the fetch sequence did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
fetch_types_pkg.sv
fetch_ctl_pkg.sv
fetch_if.sv
ifetch_tag_stage.sv
ifetch_data_stage.sv
line_fill_unit.sv
ifetch_top.sv
ifetch_properties.sv
ifetch_checker.sv
tb_ifetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch unit testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ifetch -f filelist.f -o sim_ifetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ifetch > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
